// ==== vid_raster.f ====
+incdir+.
vid_raster_pkg.sv
raster_timing.sv
aux_fifo.sv
aux_scheduler.sv
vid_raster_top.sv
vid_raster_tb_clk.sv
vid_raster_checker.sv
vid_raster_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Verilator build and run, verdict taken from the simulation log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module vid_raster_tb \
	-f vid_raster.f -o vid_raster_sim > build.log 2>&1 \
	&& ./obj_dir/vid_raster_sim > sim.log 2>&1
grep -q "TEST FAILED" sim.log && { echo "simulation failed"; exit 1; }
grep -q "TEST OK" sim.log || { echo "simulation did not pass, see build.log and sim.log"; exit 1; }
echo "simulation passed"

// ==== vid_raster_tb.sv ====
`timescale 1ns/100ps
`include "vid_raster_macros.svh"

module vid_raster_tb;
	import vid_raster_pkg::*;

	localparam int N_RAND  = 8;     // Spaced aux words
	localparam int N_FLOOD = 20;    // Back-to-back words beyond FIFO depth
	// Two VGA frames plus one SVGA frame plus aux bursts and margin
	localparam int MAX_CYCLES = 2 * 800 * 524 + 1056 * 628 + (N_RAND + N_FLOOD) * 1200 + 20000;

	logic                   clk50m_bufg;
	logic                   RSTBTN;
	logic [3:0]             format_code;
	logic                   aux_wr;
	aux_word_t              aux_din;
	video_out_t             video;
	logic                   ade;
	logic [`AUX_DATA_W-1:0] aux_data;
	logic                   aux_overflow;

	logic [31:0]   lcg_state  = 32'h90e6_e316;
	int            cycle      = 0;
	aux_word_t     exp_words[$];          // Accepted words still waiting for a burst
	video_format_e fmt        = FMT_VGA;  // Format the model runs
	video_format_e target_fmt = FMT_VGA;  // Format asked for by the stimulus
	video_out_t    prev;                  // Last sampled output
	logic          pend       = 1'b1;     // Waiting for restart at (0,0)
	logic          have_prev  = 1'b0;
	logic          seen_zero  = 1'b0;
	int            pend_cnt   = 0;
	logic          in_burst   = 1'b0;
	aux_word_t     cur_word;              // Word of the running burst
	int            burst_len  = 0;

	vid_raster_tb_clk vid_raster_tb_clk_i (.clk50m_bufg(clk50m_bufg), .RSTBTN(RSTBTN));

	vid_raster_top vid_raster_top_i (
		.clk50m_bufg  (clk50m_bufg),
		.RSTBTN       (RSTBTN),
		.format_code  (format_code),
		.aux_wr       (aux_wr),
		.aux_din      (aux_din),
		.video        (video),
		.ade          (ade),
		.aux_data     (aux_data),
		.aux_overflow (aux_overflow)
	);

	//////////////////////////////////////////////////////////////////////
	// Stimulus helpers and raster model
	//////////////////////////////////////////////////////////////////////

	function automatic logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// Start column in SVGA blanking so the burst fits in the line
	function automatic aux_word_t random_word();
		raster_timing_t t;
		aux_word_t      w;
		int             span;
		t      = timing_of(FMT_SVGA);
		span   = int'(t.h_front) + int'(t.h_sync) + int'(t.h_back) - `AUX_BURST_LEN + 1;
		w.col  = `AUX_COL_W'(int'(t.h_active) + int'(next_rand() % 32'(span)));
		w.data = `AUX_DATA_W'(next_rand() >> 8);
		return w;
	endfunction

	function automatic int frame_cycles(video_format_e f);
		raster_timing_t t;
		t = timing_of(f);
		return (int'(t.h_active) + int'(t.h_front) + int'(t.h_sync) + int'(t.h_back)) *
		       (int'(t.v_active) + int'(t.v_front) + int'(t.v_sync) + int'(t.v_back));
	endfunction

	// Sync and de for one position
	function automatic video_out_t expect_at(video_format_e f, logic [`VID_CNT_W-1:0] h,
	                                         logic [`VID_CNT_W-1:0] v);
		raster_timing_t        t;
		video_out_t            e;
		logic [`VID_CNT_W-1:0] hs0;
		logic [`VID_CNT_W-1:0] vs0;
		t        = timing_of(f);
		hs0      = t.h_active + t.h_front;
		vs0      = t.v_active + t.v_front;
		e.hcount = h;
		e.vcount = v;
		e.de     = (h < t.h_active) && (v < t.v_active);
		e.hsync  = ((h >= hs0) && (h < hs0 + t.h_sync)) ^ t.neg_pol;  // Low active if neg_pol
		e.vsync  = ((v >= vs0) && (v < vs0 + t.v_sync)) ^ t.neg_pol;
		return e;
	endfunction

	// Next output after p with wrap at line and frame end
	function automatic video_out_t step_from(video_format_e f, video_out_t p);
		raster_timing_t        t;
		logic [`VID_CNT_W-1:0] h_tot;
		logic [`VID_CNT_W-1:0] v_tot;
		logic [`VID_CNT_W-1:0] h;
		logic [`VID_CNT_W-1:0] v;
		t     = timing_of(f);
		h_tot = t.h_active + t.h_front + t.h_sync + t.h_back;
		v_tot = t.v_active + t.v_front + t.v_sync + t.v_back;
		h     = p.hcount + `VID_CNT_W'(1);
		v     = p.vcount;
		if (h == h_tot) begin
			h = '0;
			v = (p.vcount + `VID_CNT_W'(1) == v_tot) ? '0 : p.vcount + `VID_CNT_W'(1);
		end
		return expect_at(f, h, v);
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Checks
	//////////////////////////////////////////////////////////////////////

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("TEST FAILED");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic check_video(input video_out_t got, input video_out_t exp);
		if (got !== exp) begin
			abort_run($sformatf("error video: got 0x%h expected 0x%h", got, exp));
		end
	endtask

	task automatic check_aux(input string name, input logic [`AUX_DATA_W-1:0] got,
	                         input logic [`AUX_DATA_W-1:0] exp);
		if (got !== exp) begin
			abort_run($sformatf("error %s: got 0x%h expected 0x%h", name, got, exp));
		end
	endtask

	// Old sequence goes on until a single jump to (0,0) of the new format
	task automatic track_raster();
		if (!pend && target_fmt != fmt) begin
			pend      = 1'b1;
			seen_zero = 1'b0;
			pend_cnt  = 0;
		end
		if (!pend) begin
			check_video(video, step_from(fmt, prev));
		end else begin
			pend_cnt++;
			if (pend_cnt > 12) abort_run("raster did not restart at (0,0) in the new format");
			if (video === expect_at(target_fmt, '0, '0)) begin
				seen_zero = 1'b1;
			end else if (seen_zero) begin
				check_video(video, step_from(target_fmt, prev));
				fmt  = target_fmt;
				pend = 1'b0;
			end else if (have_prev) begin
				check_video(video, step_from(fmt, prev));
			end
		end
		prev      = video;
		have_prev = 1'b1;
	endtask

	task automatic track_aux();
		if (ade) begin
			if (!in_burst) begin
				if (exp_words.size() == 0) abort_run("aux burst without an accepted word");
				cur_word = exp_words.pop_front();  // Bursts come in write order
				if (video.de) abort_run("aux burst started during active video");
				check_aux("video.hcount", `AUX_DATA_W'(video.hcount),
				          `AUX_DATA_W'(cur_word.col));
				in_burst  = 1'b1;
				burst_len = 0;
			end
			burst_len++;
			check_aux("aux_data", aux_data, cur_word.data);
		end else begin
			if (in_burst) begin
				check_aux("ade length", `AUX_DATA_W'(burst_len), `AUX_DATA_W'(`AUX_BURST_LEN));
			end
			in_burst = 1'b0;
			check_aux("aux_data", aux_data, '0);
		end
	endtask

	// Outputs settle after the rising edge so sample on the falling one
	always @(negedge clk50m_bufg) begin
		if (cycle > 0) begin    // Nothing to sample before the first rising edge
			if (RSTBTN) begin
				check_aux("ade", `AUX_DATA_W'(ade), '0);
				check_aux("aux_overflow", `AUX_DATA_W'(aux_overflow), '0);
			end else begin
				track_raster();
				track_aux();
			end
		end
	end

	always @(posedge clk50m_bufg) begin
		cycle <= cycle + 1;
		if (cycle >= MAX_CYCLES) abort_run("timeout, run went past its cycle limit");
	end

	//////////////////////////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////////////////////////

	initial begin
		aux_word_t w;
		int        t_switch;
		format_code = `SW_VGA;
		aux_wr      = 1'b0;
		aux_din     = '0;
		@(posedge clk50m_bufg);
		while (RSTBTN) @(posedge clk50m_bufg);

		// Two VGA frames then a random moment for the switch
		repeat (2 * frame_cycles(FMT_VGA) + int'(next_rand() % 32'd256)) @(posedge clk50m_bufg);
		format_code <= `SW_SVGA;
		target_fmt  <= code_to_format(`SW_SVGA);
		@(posedge clk50m_bufg);
		while (pend || fmt != target_fmt) @(posedge clk50m_bufg);
		t_switch = cycle;

		for (int i = 0; i < N_RAND; i++) begin
			repeat (1 + int'(next_rand() % 32'd64)) @(posedge clk50m_bufg);
			w = random_word();
			aux_din <= w;
			aux_wr  <= 1'b1;
			exp_words.push_back(w);
			@(posedge clk50m_bufg);
			aux_wr <= 1'b0;
		end
		while (exp_words.size() != 0 || in_burst) @(posedge clk50m_bufg);
		repeat (4) @(posedge clk50m_bufg);
		check_aux("aux_overflow", `AUX_DATA_W'(aux_overflow), '0);

		// Idle scheduler takes the first word and the FIFO the next DEPTH
		for (int i = 0; i < N_FLOOD; i++) begin
			w = random_word();
			aux_din <= w;
			aux_wr  <= 1'b1;
			if (i <= `AUX_FIFO_DEPTH) exp_words.push_back(w);
			@(posedge clk50m_bufg);
		end
		aux_wr <= 1'b0;
		repeat (2) @(posedge clk50m_bufg);
		check_aux("aux_overflow", `AUX_DATA_W'(aux_overflow), `AUX_DATA_W'(1));
		while (exp_words.size() != 0 || in_burst) @(posedge clk50m_bufg);

		// Dropped words stay silent for the rest of the SVGA frame
		while (cycle < t_switch + frame_cycles(FMT_SVGA)) @(posedge clk50m_bufg);
		if (aux_overflow !== 1'b1) begin
			abort_run($sformatf("error aux_overflow: got 0x%h expected 0x1", aux_overflow));
		end else begin
			$display("TEST OK");
			$finish;
		end
	end

endmodule

// ==== vid_raster_checker.sv ====
`timescale 1ns/100ps
`include "vid_raster_macros.svh"

module vid_raster_checker (
	input logic                       clk50m_bufg,
	input logic                       RSTBTN,
	input vid_raster_pkg::video_out_t video,
	input logic                       ade,
	input logic                       aux_overflow
);

	logic [7:0] ade_run;    // Consecutive ade cycles so far

	always_ff @(posedge clk50m_bufg) begin
		if (RSTBTN) begin
			ade_run <= '0;
		end else begin
			ade_run <= ade ? ade_run + 8'd1 : 8'd0;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Burst length, burst placement, sticky overflow
	//////////////////////////////////////////////////////////////////////

	burst_end_a: assert property (@(posedge clk50m_bufg) disable iff (RSTBTN)
		$fell(ade) |-> ade_run == 8'(`AUX_BURST_LEN))
		else $error("aux burst ended after %0d cycles", ade_run);

	burst_max_a: assert property (@(posedge clk50m_bufg) disable iff (RSTBTN)
		ade |-> ade_run < 8'(`AUX_BURST_LEN))
		else $error("aux burst longer than allowed");

	blank_only_a: assert property (@(posedge clk50m_bufg) disable iff (RSTBTN)
		!(ade && video.de))
		else $error("ade high during active video");

	sticky_ovf_a: assert property (@(posedge clk50m_bufg) disable iff (RSTBTN)
		!$fell(aux_overflow))
		else $error("aux_overflow cleared outside reset");

endmodule

bind vid_raster_top vid_raster_checker vid_raster_checker_i (
	.clk50m_bufg  (clk50m_bufg),
	.RSTBTN       (RSTBTN),
	.video        (video),
	.ade          (ade),
	.aux_overflow (aux_overflow)
);

// ==== vid_raster_tb_clk.sv ====
`timescale 1ns/100ps

module vid_raster_tb_clk (
	output logic clk50m_bufg,
	output logic RSTBTN
);

	// 50 MHz, 20 ns period
	initial begin
		clk50m_bufg = 1'b0;
		forever #10 clk50m_bufg = ~clk50m_bufg;
	end

	initial begin
		RSTBTN = 1'b1;
		repeat (5) @(posedge clk50m_bufg);  // Five reset cycles
		RSTBTN <= 1'b0;
	end

endmodule

// ==== vid_raster_top.sv ====
`timescale 1ns/100ps
`include "vid_raster_macros.svh"

module vid_raster_top (
	input  logic                       clk50m_bufg,
	input  logic                       RSTBTN,
	input  logic [3:0]                 format_code,
	input  logic                       aux_wr,       // Single-cycle write strobe
	input  vid_raster_pkg::aux_word_t  aux_din,
	output vid_raster_pkg::video_out_t video,
	output logic                       ade,
	output logic [`AUX_DATA_W-1:0]     aux_data,
	output logic                       aux_overflow
);
	import vid_raster_pkg::*;

	// FIFO to scheduler
	aux_word_t rd_dout;
	logic      rd_en;
	logic      empty;

	//////////////////////////////////////////////////////////////////////
	// Raster timing, aux FIFO, aux scheduler
	//////////////////////////////////////////////////////////////////////

	raster_timing raster_timing_i (
		.clk50m_bufg (clk50m_bufg),
		.RSTBTN      (RSTBTN),
		.format_code (format_code),
		.video       (video)        // Also feeds the scheduler
	);

	aux_fifo aux_fifo_i (
		.clk50m_bufg  (clk50m_bufg),
		.RSTBTN       (RSTBTN),
		.aux_wr       (aux_wr),
		.aux_din      (aux_din),
		.rd_en        (rd_en),
		.rd_dout      (rd_dout),
		.empty        (empty),
		.aux_overflow (aux_overflow)
	);

	aux_scheduler aux_scheduler_i (
		.clk50m_bufg (clk50m_bufg),
		.RSTBTN      (RSTBTN),
		.video       (video),
		.empty       (empty),
		.rd_dout     (rd_dout),
		.rd_en       (rd_en),
		.ade         (ade),
		.aux_data    (aux_data)
	);

endmodule

// ==== aux_scheduler.sv ====
`timescale 1ns/100ps
`include "vid_raster_macros.svh"

module aux_scheduler (
	input  logic                       clk50m_bufg,
	input  logic                       RSTBTN,
	input  vid_raster_pkg::video_out_t video,
	input  logic                       empty,
	input  vid_raster_pkg::aux_word_t  rd_dout,
	output logic                       rd_en,
	output logic                       ade,
	output logic [`AUX_DATA_W-1:0]     aux_data
);
	import vid_raster_pkg::*;

	localparam int BURST_W = $clog2(`AUX_BURST_LEN);
	localparam logic [BURST_W-1:0] BURST_LAST = BURST_W'(`AUX_BURST_LEN - 1);

	aux_state_e         state;
	aux_word_t          word_q;     // Word being placed
	logic [BURST_W-1:0] burst_cnt;  // Burst cycles done so far
	logic               col_hit;
	logic               start;

	//////////////////////////////////////////////////////////////////////
	// Column match in blanking
	//////////////////////////////////////////////////////////////////////

	assign col_hit = (`AUX_COL_W'(video.hcount) == word_q.col);
	assign start   = (state == WAIT) && !video.de && col_hit;

	// First burst cycle is the match cycle itself
	assign ade      = start || (state == BURST);
	assign aux_data = ade ? word_q.data : '0;   // Zero outside the burst

	// One pop per word, only from IDLE
	assign rd_en = (state == IDLE) && !empty;

	//////////////////////////////////////////////////////////////////////
	// FSM
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk50m_bufg) begin
		if (RSTBTN) begin
			state     <= IDLE;
			burst_cnt <= '0;
		end else begin
			case (state)
				IDLE: begin
					if (!empty) state <= LOAD;   // rd_en pulses here
				end
				LOAD: begin
					state <= WAIT;               // rd_dout valid now
				end
				WAIT: begin
					if (start) begin
						state     <= BURST;
						burst_cnt <= BURST_W'(1);  // Match cycle counted
					end
				end
				BURST: begin
					if (burst_cnt == BURST_LAST) begin
						state <= IDLE;           // 32nd cycle of ade
					end else begin
						burst_cnt <= burst_cnt + 1'b1;
					end
				end
			endcase
		end
	end

	// Capture popped word
	always_ff @(posedge clk50m_bufg) begin
		if (state == LOAD) begin
			word_q <= rd_dout;
		end
	end

endmodule

// ==== aux_fifo.sv ====
`timescale 1ns/100ps
`include "vid_raster_macros.svh"

module aux_fifo (
	input  logic                      clk50m_bufg,
	input  logic                      RSTBTN,
	input  logic                      aux_wr,
	input  vid_raster_pkg::aux_word_t aux_din,
	input  logic                      rd_en,
	output vid_raster_pkg::aux_word_t rd_dout,
	output logic                      empty,
	output logic                      aux_overflow
);
	import vid_raster_pkg::*;

	localparam int PTR_W = $clog2(`AUX_FIFO_DEPTH);

	aux_word_t        mem [`AUX_FIFO_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W:0]   count;    // One spare bit to hold the full count
	logic             full;
	logic             do_wr;
	logic             do_rd;

	assign full  = count[PTR_W];          // Only set at full depth
	assign empty = (count == '0);
	assign do_wr = aux_wr && !full;       // Write to full FIFO is lost
	assign do_rd = rd_en && !empty;

	//////////////////////////////////////////////////////////////////////
	// Storage and registered read port
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk50m_bufg) begin
		if (do_wr) begin
			mem[wr_ptr] <= aux_din;
		end
		if (do_rd) begin
			rd_dout <= mem[rd_ptr];   // Valid the cycle after rd_en
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Pointers, fill count, overflow
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk50m_bufg) begin
		if (RSTBTN) begin
			wr_ptr       <= '0;
			rd_ptr       <= '0;
			count        <= '0;
			aux_overflow <= 1'b0;
		end else begin
			if (do_wr) wr_ptr <= wr_ptr + 1'b1;
			if (do_rd) rd_ptr <= rd_ptr + 1'b1;
			case ({do_wr, do_rd})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;    // Idle or both, no change
			endcase
			// Sticky until reset
			if (aux_wr && full) begin
				aux_overflow <= 1'b1;
			end
		end
	end

endmodule

// ==== raster_timing.sv ====
`timescale 1ns/100ps
`include "vid_raster_macros.svh"

module raster_timing (
	input  logic                       clk50m_bufg,
	input  logic                       RSTBTN,
	input  logic [3:0]                 format_code,
	output vid_raster_pkg::video_out_t video
);
	import vid_raster_pkg::*;

	localparam logic [`VID_CNT_W-1:0] CNT_ZERO = `VID_CNT_W'd0;
	localparam logic [`VID_CNT_W-1:0] CNT_ONE  = `VID_CNT_W'd1;

	//////////////////////////////////////////////////////////////////////
	// Format selection
	//////////////////////////////////////////////////////////////////////

	logic [3:0]     code_q;     // Switch code, sampled every cycle
	logic [3:0]     cur_code;   // Code behind the running format
	raster_timing_t tm;         // Timing of the running format
	logic           restart;

	// New code or reset puts the raster back at (0,0)
	assign restart = RSTBTN || (code_q != cur_code);

	//////////////////////////////////////////////////////////////////////
	// Counter limits and sync windows
	//////////////////////////////////////////////////////////////////////

	logic [`VID_CNT_W-1:0] hs_start;
	logic [`VID_CNT_W-1:0] hs_end;
	logic [`VID_CNT_W-1:0] h_last;    // Last column of a line
	logic [`VID_CNT_W-1:0] vs_start;
	logic [`VID_CNT_W-1:0] vs_end;
	logic [`VID_CNT_W-1:0] v_last;    // Last line of a frame

	assign hs_start = tm.h_active + tm.h_front;
	assign hs_end   = hs_start + tm.h_sync;
	assign h_last   = hs_end + tm.h_back - CNT_ONE;

	assign vs_start = tm.v_active + tm.v_front;
	assign vs_end   = vs_start + tm.v_sync;
	assign v_last   = vs_end + tm.v_back - CNT_ONE;

	//////////////////////////////////////////////////////////////////////
	// Pixel and line counters
	//////////////////////////////////////////////////////////////////////

	logic [`VID_CNT_W-1:0] hcnt;
	logic [`VID_CNT_W-1:0] vcnt;

	always_ff @(posedge clk50m_bufg) begin
		code_q <= format_code;    // Also runs during reset
		if (restart) begin
			cur_code <= code_q;
			tm       <= timing_of(code_to_format(code_q));
			hcnt     <= CNT_ZERO;
			vcnt     <= CNT_ZERO;
		end else if (hcnt == h_last) begin
			hcnt <= CNT_ZERO;         // End of line
			if (vcnt == v_last) begin
				vcnt <= CNT_ZERO;     // End of frame
			end else begin
				vcnt <= vcnt + CNT_ONE;
			end
		end else begin
			hcnt <= hcnt + CNT_ONE;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Sync and blank decode
	//////////////////////////////////////////////////////////////////////

	logic hs_on;    // Inside hsync window, before polarity
	logic vs_on;
	logic active;

	assign hs_on  = (hcnt >= hs_start) && (hcnt < hs_end);
	assign vs_on  = (vcnt >= vs_start) && (vcnt < vs_end);
	assign active = (hcnt < tm.h_active) && (vcnt < tm.v_active);

	// Two register stages between counters and output
	video_out_t stage1;

	always_ff @(posedge clk50m_bufg) begin
		stage1.hsync  <= hs_on ^ tm.neg_pol;  // Flip level for negative sync
		stage1.vsync  <= vs_on ^ tm.neg_pol;
		stage1.de     <= active;
		stage1.hcount <= hcnt;
		stage1.vcount <= vcnt;
		video         <= stage1;
	end

endmodule

// ==== vid_raster_pkg.sv ====
`include "vid_raster_macros.svh"

package vid_raster_pkg;

	//////////////////////////////////////////////////////////////////////
	// Enumerations
	//////////////////////////////////////////////////////////////////////

	typedef enum logic [2:0] {
		FMT_VGA,
		FMT_SVGA,
		FMT_XGA,
		FMT_HD720,
		FMT_SXGA,
		FMT_CAMERA
	} video_format_e;

	// Aux scheduler FSM
	typedef enum logic [1:0] {
		IDLE,   // Waiting for a word in the FIFO
		LOAD,   // FIFO read data arriving
		WAIT,   // Hunting for the start column in blanking
		BURST   // Aux enable running
	} aux_state_e;

	//////////////////////////////////////////////////////////////////////
	// Structs
	//////////////////////////////////////////////////////////////////////

	typedef struct packed {
		logic [`VID_CNT_W-1:0] h_active;   // Live pixels
		logic [`VID_CNT_W-1:0] h_front;
		logic [`VID_CNT_W-1:0] h_sync;     // Hsync pulse width
		logic [`VID_CNT_W-1:0] h_back;
		logic [`VID_CNT_W-1:0] v_active;   // Live lines
		logic [`VID_CNT_W-1:0] v_front;
		logic [`VID_CNT_W-1:0] v_sync;     // Vsync pulse width
		logic [`VID_CNT_W-1:0] v_back;
		logic                  neg_pol;    // Sync active low
	} raster_timing_t;

	typedef struct packed {
		logic                  hsync;
		logic                  vsync;
		logic                  de;
		logic [`VID_CNT_W-1:0] hcount;
		logic [`VID_CNT_W-1:0] vcount;
	} video_out_t;

	typedef struct packed {
		logic [`AUX_COL_W-1:0]  col;    // Burst start column
		logic [`AUX_DATA_W-1:0] data;
	} aux_word_t;

	//////////////////////////////////////////////////////////////////////
	// Format lookup
	//////////////////////////////////////////////////////////////////////

	// Order: h act/fp/sync/bp, v act/fp/sync/bp, negative polarity
	function automatic raster_timing_t timing_of(video_format_e fmt);
		raster_timing_t t;
		case (fmt)
			FMT_VGA:    t = '{11'd640, 11'd16, 11'd96, 11'd48, 11'd480, 11'd11, 11'd2, 11'd31, 1'b1};
			FMT_SVGA:   t = '{11'd800, 11'd40, 11'd128, 11'd88, 11'd600, 11'd1, 11'd4, 11'd23, 1'b0};
			FMT_XGA:    t = '{11'd1024, 11'd24, 11'd136, 11'd160, 11'd768, 11'd3, 11'd6, 11'd29, 1'b1};
			FMT_SXGA:   t = '{11'd1280, 11'd48, 11'd112, 11'd248, 11'd1024, 11'd1, 11'd3, 11'd38, 1'b0};
			FMT_CAMERA: t = '{11'd1280, 11'd110, 11'd39, 11'd220, 11'd720, 11'd4, 11'd4, 11'd22, 1'b0};
			default:    t = '{11'd1280, 11'd110, 11'd40, 11'd220, 11'd720, 11'd5, 11'd5, 11'd20, 1'b0};
		endcase
		return t;
	endfunction

	function automatic video_format_e code_to_format(logic [3:0] code);
		case (code)
			`SW_VGA:    return FMT_VGA;
			`SW_SVGA:   return FMT_SVGA;
			`SW_XGA:    return FMT_XGA;
			`SW_SXGA:   return FMT_SXGA;
			`SW_CAMERA: return FMT_CAMERA;
			default:    return FMT_HD720;  // SW_HD720 and unlisted codes
		endcase
	endfunction

endpackage

// ==== vid_raster_macros.svh ====
`ifndef VID_RASTER_MACROS_SVH
`define VID_RASTER_MACROS_SVH

//////////////////////////////////////////////////////////////////////
// Raster counters
//////////////////////////////////////////////////////////////////////

// Pixel and line counter width, covers the largest total (SXGA 1688)
`define VID_CNT_W        11

//////////////////////////////////////////////////////////////////////
// Aux data words
//////////////////////////////////////////////////////////////////////

`define AUX_COL_W        12   // Start column field, upper half of word
`define AUX_DATA_W       12   // Payload field, lower half of word

// Cycles of aux enable per word
`define AUX_BURST_LEN    32

// Aux word FIFO entries, power of two
`define AUX_FIFO_DEPTH   16

//////////////////////////////////////////////////////////////////////
// Format switch codes
//////////////////////////////////////////////////////////////////////

`define SW_VGA           4'b0000  // 640x480, negative sync
`define SW_SVGA          4'b0001  // 800x600
`define SW_XGA           4'b0011  // 1024x768, negative sync
`define SW_HD720         4'b0010  // 1280x720, also the fallback
`define SW_SXGA          4'b1000  // 1280x1024
`define SW_CAMERA        4'b1001  // 1280x720 with camera porches

// Any other code falls back to HD720

`endif
